// ==== rtl/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// address and instruction word width
`define FETCH_XLEN 32

// table depths, both tables index through the same address view
`define FETCH_SETS 16
`define BTB_SETS 16

// number of interrupt request lines
`define IRQ_LINES 4

//////////////////////////////////////////////////////////////////////
// fixed addresses
//////////////////////////////////////////////////////////////////////

// first fetch after reset
`define RESET_VEC 32'h0000_0000
// vector table base and spacing in bytes
`define VEC_BASE 32'h0000_0100
`define VEC_STRIDE 32'd16

`endif

// ==== rtl/fetchPkg.sv ====
`include "fetch_params.svh"

package fetchPkg;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    // set index width, shared by cache and predictor
    localparam int IDX_W = $clog2(`FETCH_SETS);
    // what is left above index and byte offset
    localparam int TAG_W = `FETCH_XLEN - IDX_W - 2;

    // tag / index / byte offset split of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [1:0]       offset;
    } fetchAddrS;

    // same word, flat or split
    typedef union packed {
        logic [`FETCH_XLEN-1:0] word;
        fetchAddrS              f;
    } fetchAddrU;

    //////////////////////////////////////////////////////////////////////
    // stage to stage bundles
    //////////////////////////////////////////////////////////////////////

    // IF/ID packet
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] instr;
        logic                   predTaken;
    } fetchPktS;

    // branch outcome coming back from a later stage
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] target;
        logic                   taken;
    } resolveS;

    // predictor answer for the current fetch address
    typedef struct packed {
        logic                   taken;
        logic [`FETCH_XLEN-1:0] target;
    } predictS;

    // interrupt vector redirect
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] addr;
    } redirectS;

endpackage

// ==== rtl/pcUpdate.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module pcUpdate
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] jmpAddr,
    input  logic                   idStall,
    input  fetchPkg::redirectS     redirect,
    input  fetchPkg::predictS      predict,
    input  logic                   hit,
    input  logic                   miss,
    input  logic [`FETCH_XLEN-1:0] instr,
    output logic [`FETCH_XLEN-1:0] fetchAddr,
    output fetchPkg::fetchPktS     fetchPkt
);

    // next fetch address
    logic [`FETCH_XLEN-1:0] nextAddr;
    // fetch address stays put
    logic holdPc;
    // current fetch is thrown away
    logic killPkt;

    // IF/ID register, valid bit apart from payload
    logic                   pktValid;
    logic [`FETCH_XLEN-1:0] pktPc;
    logic [`FETCH_XLEN-1:0] pktInstr;
    logic                   pktPredTaken;

    //////////////////////////////////////////////////////////////////////
    // next address select
    //////////////////////////////////////////////////////////////////////

    // miss waits for refill, stall waits for decode
    assign holdPc = miss || idStall;
    assign killPkt = redirect.valid || flush;

    // fixed priority: vector, flush, hold, predicted, sequential
    always_comb
    begin
        if (redirect.valid)
            nextAddr = redirect.addr;
        else if (flush)
            nextAddr = jmpAddr;
        else if (holdPc)
            nextAddr = fetchAddr;
        else if (predict.taken)
            nextAddr = predict.target;
        else
            nextAddr = fetchAddr + `FETCH_XLEN'(4);
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            fetchAddr <= `RESET_VEC;
        else
            fetchAddr <= nextAddr;
    end

    //////////////////////////////////////////////////////////////////////
    // IF/ID register
    //////////////////////////////////////////////////////////////////////

    // redirect or flush beats the stall and leaves a bubble
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            pktValid <= 1'b0;
        else if (killPkt)
            pktValid <= 1'b0;
        else if (!idStall)
            pktValid <= hit;
    end

    // payload only moves on a real hit
    always_ff @(posedge Clk)
    begin
        if (!killPkt && !idStall && hit)
        begin
            pktPc        <= fetchAddr;
            pktInstr     <= instr;
            pktPredTaken <= predict.taken;
        end
    end

    assign fetchPkt = '{valid: pktValid, pc: pktPc, instr: pktInstr, predTaken: pktPredTaken};

    // never unknown while running
    assert property (@(posedge Clk) disable iff (!arstN) !$isunknown(fetchAddr));
    // jump, vector and predicted targets all land on word boundaries
    assert property (@(posedge Clk) disable iff (!arstN) fetchAddr[1:0] == 2'b00);

endmodule

// ==== rtl/branchPredictor.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module branchPredictor
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic [`FETCH_XLEN-1:0] fetchAddr,
    input  fetchPkg::resolveS      resolve,
    output fetchPkg::predictS      predict
);

    // BTB entry fields, one array per field
    logic [`BTB_SETS-1:0]           btbValid;
    logic [fetchPkg::TAG_W-1:0]     btbTag    [`BTB_SETS];
    logic [`FETCH_XLEN-1:0]         btbTarget [`BTB_SETS];
    logic [1:0]                     btbCnt    [`BTB_SETS];

    // lookup side
    fetchPkg::fetchAddrU            lookAddr;
    logic [fetchPkg::IDX_W-1:0]     lookIdx;
    logic                           lookMatch;

    // training side
    fetchPkg::fetchAddrU            resAddr;
    logic [fetchPkg::IDX_W-1:0]     resIdx;
    logic                           resMatch;

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    assign lookAddr.word = fetchAddr;
    assign lookIdx = lookAddr.f.index;
    assign lookMatch = btbValid[lookIdx] && (btbTag[lookIdx] == lookAddr.f.tag);

    // counter msb set means weakly or strongly taken
    assign predict = '{taken: lookMatch && btbCnt[lookIdx][1], target: btbTarget[lookIdx]};

    //////////////////////////////////////////////////////////////////////
    // training
    //////////////////////////////////////////////////////////////////////

    assign resAddr.word = resolve.pc;
    assign resIdx = resAddr.f.index;
    assign resMatch = btbValid[resIdx] && (btbTag[resIdx] == resAddr.f.tag);

    // only a taken branch claims an entry
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            btbValid <= '0;
        else if (resolve.valid && resolve.taken)
            btbValid[resIdx] <= 1'b1;
    end

    always_ff @(posedge Clk)
    begin
        if (resolve.valid)
        begin
            if (resolve.taken)
            begin
                // saturating increment on a hit
                if (resMatch)
                begin
                    if (btbCnt[resIdx] != 2'b11)
                        btbCnt[resIdx] <= btbCnt[resIdx] + 2'd1;
                end
                // new or evicted entry, start weakly taken
                else
                begin
                    btbTag[resIdx] <= resAddr.f.tag;
                    btbCnt[resIdx] <= 2'b10;
                end
                btbTarget[resIdx] <= resolve.target;
            end
            // not taken only weakens a matching entry
            else if (resMatch && btbCnt[resIdx] != 2'b00)
            begin
                btbCnt[resIdx] <= btbCnt[resIdx] - 2'd1;
            end
        end
    end

    // taken prediction needs a live entry under that index
    assert property (@(posedge Clk) disable iff (!arstN) predict.taken |-> btbValid[lookIdx]);

endmodule

// ==== rtl/instrCache.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module instrCache
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic [`FETCH_XLEN-1:0] fetchAddr,
    output logic                   hit,
    output logic                   miss,
    output logic [`FETCH_XLEN-1:0] instr,
    output logic                   memReq,
    output logic [`FETCH_XLEN-1:0] memAddr,
    input  logic                   memValid,
    input  logic [`FETCH_XLEN-1:0] memData
);

    // one word per line
    logic [`FETCH_SETS-1:0]         cValid;
    logic [fetchPkg::TAG_W-1:0]     cTag  [`FETCH_SETS];
    logic [`FETCH_XLEN-1:0]         cData [`FETCH_SETS];

    // fetch side decode
    fetchPkg::fetchAddrU            rdAddr;
    logic [fetchPkg::IDX_W-1:0]     rdIdx;

    // refill side decode, from the latched request address
    fetchPkg::fetchAddrU            wrAddr;
    logic                           refillDone;

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    assign rdAddr.word = fetchAddr;
    assign rdIdx = rdAddr.f.index;

    assign hit = cValid[rdIdx] && (cTag[rdIdx] == rdAddr.f.tag);
    assign miss = !hit;
    assign instr = cData[rdIdx];

    //////////////////////////////////////////////////////////////////////
    // refill
    //////////////////////////////////////////////////////////////////////

    // memory data lands on this edge
    assign refillDone = memReq && memValid;
    assign wrAddr.word = memAddr;

    // request level rises after a miss, drops with the data strobe
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            memReq <= 1'b0;
        else if (memReq)
            memReq <= !memValid;
        else
            memReq <= miss;
    end

    // address held steady for the whole request
    always_ff @(posedge Clk)
    begin
        if (!memReq && miss)
            memAddr <= fetchAddr;
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            cValid <= '0;
        else if (refillDone)
            cValid[wrAddr.f.index] <= 1'b1;
    end

    always_ff @(posedge Clk)
    begin
        if (refillDone)
        begin
            cTag[wrAddr.f.index]  <= wrAddr.f.tag;
            cData[wrAddr.f.index] <= memData;
        end
    end

    // memory side must not answer without an open request
    assert property (@(posedge Clk) disable iff (!arstN) memValid |-> memReq);
    // refilled line reads back as a hit while the fetch stays on it
    assert property (@(posedge Clk) disable iff (!arstN)
        refillDone |=> hit || fetchAddr != $past(memAddr));

endmodule

// ==== rtl/vectorCtrl.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module vectorCtrl
(
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic [`IRQ_LINES-1:0] irq,
    output fetchPkg::redirectS    redirect
);

    localparam int IRQ_W = $clog2(`IRQ_LINES);

    // requests seen but not yet vectored
    logic [`IRQ_LINES-1:0] pending;
    // lowest pending line this cycle
    logic                  pickAny;
    logic [IRQ_W-1:0]      pickIdx;
    logic [`IRQ_LINES-1:0] clearMask;

    // registered redirect
    logic                  redValid;
    logic [IRQ_W-1:0]      redIdx;

    //////////////////////////////////////////////////////////////////////
    // priority pick
    //////////////////////////////////////////////////////////////////////

    // scan downward so the lowest set bit wins
    always_comb
    begin
        pickAny = 1'b0;
        pickIdx = '0;
        for (int i = `IRQ_LINES - 1; i >= 0; i--)
        begin
            if (pending[i])
            begin
                pickAny = 1'b1;
                pickIdx = IRQ_W'(i);
            end
        end
    end

    assign clearMask = pickAny ? (`IRQ_LINES'(1) << pickIdx) : '0;

    // new pulses merge in while the picked bit clears
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pending  <= '0;
            redValid <= 1'b0;
        end
        else
        begin
            pending  <= (pending & ~clearMask) | irq;
            redValid <= pickAny;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (pickAny)
            redIdx <= pickIdx;
    end

    // vector entry address
    assign redirect = '{valid: redValid, addr: `VEC_BASE + `FETCH_XLEN'(redIdx) * `VEC_STRIDE};

    // back to back redirects must come from different lines
    assert property (@(posedge Clk) disable iff (!arstN)
        redValid ##1 redValid |-> redIdx != $past(redIdx));

endmodule

// ==== rtl/fetchTop.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetchTop
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] jmpAddr,
    input  logic                   idStall,
    input  fetchPkg::resolveS      resolve,
    input  logic [`IRQ_LINES-1:0]  irq,
    output logic                   memReq,
    output logic [`FETCH_XLEN-1:0] memAddr,
    input  logic                   memValid,
    input  logic [`FETCH_XLEN-1:0] memData,
    output fetchPkg::fetchPktS     fetchPkt
);

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////

    // current fetch address, to cache and predictor
    logic [`FETCH_XLEN-1:0] fetchAddr;
    // same cycle cache answer
    logic                   hit;
    logic                   miss;
    logic [`FETCH_XLEN-1:0] instr;
    // predictor answer
    fetchPkg::predictS      predict;
    // interrupt vector
    fetchPkg::redirectS     redirect;

    pcUpdate i_pcUpdate
    (
        .Clk       (Clk),
        .arstN     (arstN),
        .flush     (flush),
        .jmpAddr   (jmpAddr),
        .idStall   (idStall),
        .redirect  (redirect),
        .predict   (predict),
        .hit       (hit),
        .miss      (miss),
        .instr     (instr),
        .fetchAddr (fetchAddr),
        .fetchPkt  (fetchPkt)
    );

    branchPredictor i_branchPredictor
    (
        .Clk       (Clk),
        .arstN     (arstN),
        .fetchAddr (fetchAddr),
        .resolve   (resolve),
        .predict   (predict)
    );

    instrCache i_instrCache
    (
        .Clk       (Clk),
        .arstN     (arstN),
        .fetchAddr (fetchAddr),
        .hit       (hit),
        .miss      (miss),
        .instr     (instr),
        .memReq    (memReq),
        .memAddr   (memAddr),
        .memValid  (memValid),
        .memData   (memData)
    );

    vectorCtrl i_vectorCtrl
    (
        .Clk       (Clk),
        .arstN     (arstN),
        .irq       (irq),
        .redirect  (redirect)
    );

endmodule

// ==== bench/fetchChecker.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetchChecker
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] jmpAddr,
    input  logic                   idStall,
    input  fetchPkg::resolveS      resolve,
    input  logic [`IRQ_LINES-1:0]  irq,
    input  logic                   memReq,
    input  logic [`FETCH_XLEN-1:0] memAddr,
    input  logic                   memValid,
    input  fetchPkg::fetchPktS     fetchPkt,
    output int                     pktCount,
    output int                     checkCount,
    output int                     errCount
);

    // pc the next new valid packet must carry
    logic [`FETCH_XLEN-1:0]     expNext;
    fetchPkg::fetchPktS         lastPkt;
    logic                       prevKill;
    logic                       prevStall;
    logic                       prevMemReq;
    // BTB model, trained one cycle late to match the DUT lookup
    logic                       mbValid  [`BTB_SETS];
    logic [fetchPkg::TAG_W-1:0] mbTag    [`BTB_SETS];
    logic [`FETCH_XLEN-1:0]     mbTarget [`BTB_SETS];
    logic [1:0]                 mbCnt    [`BTB_SETS];
    fetchPkg::resolveS          heldRes;
    // cache contents rebuilt from observed refills
    logic                       mcValid [`FETCH_SETS];
    logic [fetchPkg::TAG_W-1:0] mcTag   [`FETCH_SETS];
    // interrupt model
    logic [`IRQ_LINES-1:0]      vPending;
    logic                       redActive;
    int                         redIdx;
    int                         nPkts = 0;
    int                         nChecks = 0;
    int                         nErrors = 0;

    assign pktCount = nPkts;
    assign checkCount = nChecks;
    assign errCount = nErrors;

    //////////////////////////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////////////////////////

    // memory image, same formula as the bench memory
    function automatic logic [`FETCH_XLEN-1:0] memWord(input logic [`FETCH_XLEN-1:0] addr);
        logic [`FETCH_XLEN-1:0] x;
        x = addr ^ 32'h5A3C_96E1;
        return {x[24:0], x[31:25]};
    endfunction

    // taken when entry live, tag equal, counter at least 2
    function automatic logic predictHit(input logic [`FETCH_XLEN-1:0] pc);
        fetchPkg::fetchAddrU a;
        a.word = pc;
        return mbValid[a.f.index] && mbTag[a.f.index] == a.f.tag && mbCnt[a.f.index] >= 2'd2;
    endfunction

    function automatic logic [`FETCH_XLEN-1:0] predictTarget(input logic [`FETCH_XLEN-1:0] pc);
        fetchPkg::fetchAddrU a;
        a.word = pc;
        return mbTarget[a.f.index];
    endfunction

    function automatic logic cacheHolds(input logic [`FETCH_XLEN-1:0] addr);
        fetchPkg::fetchAddrU a;
        a.word = addr;
        return mcValid[a.f.index] && mcTag[a.f.index] == a.f.tag;
    endfunction

    task automatic trainModel(input fetchPkg::resolveS r);
        fetchPkg::fetchAddrU a;
        logic                m;
        a.word = r.pc;
        m = mbValid[a.f.index] && mbTag[a.f.index] == a.f.tag;
        if (r.valid && r.taken)
        begin
            if (!m)
            begin
                // fresh entry starts weakly taken
                mbValid[a.f.index] = 1'b1;
                mbTag[a.f.index] = a.f.tag;
                mbCnt[a.f.index] = 2'd2;
            end
            else if (mbCnt[a.f.index] != 2'd3)
                mbCnt[a.f.index] = mbCnt[a.f.index] + 2'd1;
            mbTarget[a.f.index] = r.target;
        end
        else if (r.valid && m && mbCnt[a.f.index] != 2'd0)
            mbCnt[a.f.index] = mbCnt[a.f.index] - 2'd1;
    endtask

    task automatic reportMismatch(input string field, input logic [`FETCH_XLEN-1:0] got,
                                  input logic [`FETCH_XLEN-1:0] exp);
        nErrors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, field, got, exp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // per cycle compare, sampled mid cycle
    //////////////////////////////////////////////////////////////////////

    task automatic resetModel();
        expNext = `RESET_VEC;
        prevKill = 1'b0;
        prevStall = 1'b0;
        prevMemReq = 1'b0;
        heldRes = '0;
        vPending = '0;
        redActive = 1'b0;
        redIdx = 0;
        for (int i = 0; i < `BTB_SETS; i++)
            mbValid[i] = 1'b0;
        for (int i = 0; i < `FETCH_SETS; i++)
            mcValid[i] = 1'b0;
        nChecks++;
        if (fetchPkt.valid !== 1'b0 || memReq !== 1'b0)
        begin
            nErrors++;
            $display("error at %0t: packet valid or memReq set during reset", $time);
        end
    endtask

    task automatic checkPacket();
        logic taken;
        nPkts++;
        nChecks++;
        if (fetchPkt.pc !== expNext)
            reportMismatch("pc", fetchPkt.pc, expNext);
        if (fetchPkt.instr !== memWord(fetchPkt.pc))
            reportMismatch("instr", fetchPkt.instr, memWord(fetchPkt.pc));
        taken = predictHit(fetchPkt.pc);
        if (fetchPkt.predTaken !== taken)
            reportMismatch("predTaken", 32'(fetchPkt.predTaken), 32'(taken));
        // follow the real pc so one slip does not cascade
        expNext = taken ? predictTarget(fetchPkt.pc) : fetchPkt.pc + 32'd4;
    endtask

    task automatic stepModel();
        logic                killNow;
        int                  pick;
        fetchPkg::fetchAddrU a;
        killNow = flush || redActive;
        // IF/ID register
        if (prevKill)
        begin
            nChecks++;
            if (fetchPkt.valid !== 1'b0)
                reportMismatch("bubble valid", 32'(fetchPkt.valid), 32'd0);
        end
        else if (prevStall)
        begin
            nChecks++;
            if (fetchPkt !== lastPkt)
                reportMismatch("held packet pc", fetchPkt.pc, lastPkt.pc);
        end
        else if (fetchPkt.valid)
            checkPacket();
        // a new request must be for a line not yet held
        if (memReq && !prevMemReq)
        begin
            nChecks++;
            if (cacheHolds(memAddr))
            begin
                nErrors++;
                $display("error at %0t: refill requested for cached address %h", $time, memAddr);
            end
            // unless the missed fetch was thrown away, it is the pc awaited next
            if (!prevKill && memAddr !== expNext)
                reportMismatch("memAddr", memAddr, expNext);
        end
        // vector beats flush
        if (flush)
            expNext = jmpAddr;
        if (redActive)
            expNext = `VEC_BASE + `FETCH_XLEN'(redIdx) * `VEC_STRIDE;
        if (memReq && memValid)
        begin
            a.word = memAddr;
            mcValid[a.f.index] = 1'b1;
            mcTag[a.f.index] = a.f.tag;
        end
        trainModel(heldRes);
        heldRes = resolve;
        // lowest pending line goes out next cycle
        pick = -1;
        for (int i = `IRQ_LINES - 1; i >= 0; i--)
            if (vPending[i])
                pick = i;
        redActive = (pick >= 0);
        if (pick >= 0)
        begin
            redIdx = pick;
            vPending[pick] = 1'b0;
        end
        vPending = vPending | irq;
        prevKill = killNow;
        prevStall = idStall;
        prevMemReq = memReq;
        lastPkt = fetchPkt;
    endtask

    always @(negedge Clk)
    begin
        if (!arstN)
            resetModel();
        else
            stepModel();
    end

endmodule

// ==== bench/fetchTb.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetchTb;

    localparam int RESET_CYCLES = 10;
    localparam int STALL_CYCLES = 6;
    // packets awaited per phase
    localparam int P1_PKTS = 20;
    localparam int P2_PKTS = 10;
    localparam int P3_PKTS = 8;
    localparam int P4_PKTS = 6;
    localparam int P5_PKTS = 10;
    localparam int NUM_PHASES = 5;
    // worst cold fetch, miss plus request plus 4 wait cycles
    localparam int REFILL_MAX = 6;
    localparam int PHASE_SUM = RESET_CYCLES + STALL_CYCLES
        + (P1_PKTS + P2_PKTS + 2 * P3_PKTS + 2 * P4_PKTS + P5_PKTS) * REFILL_MAX;
    localparam int TIMEOUT_CYCLES = 2 * PHASE_SUM + NUM_PHASES * REFILL_MAX;
    // branch used for training
    localparam logic [`FETCH_XLEN-1:0] BR_PC = 32'h30;
    localparam logic [`FETCH_XLEN-1:0] BR_TGT = 32'h200;

    logic                   Clk = 1'b0;
    logic                   arstN;
    logic                   flush;
    logic [`FETCH_XLEN-1:0] jmpAddr;
    logic                   idStall;
    fetchPkg::resolveS      resolve;
    logic [`IRQ_LINES-1:0]  irq;
    logic                   memReq;
    logic [`FETCH_XLEN-1:0] memAddr;
    logic                   memValid = 1'b0;
    logic [`FETCH_XLEN-1:0] memData = '0;
    fetchPkg::fetchPktS     fetchPkt;
    int                     pktCount;
    int                     checkCount;
    int                     errCount;
    // memory model and run limit state
    logic [31:0]            rngState = 32'd5571;
    int                     refillWait = -1;
    int                     cycleCount = 0;
    int                     benchErrors = 0;

    fetchTop i_fetchTop (.Clk, .arstN, .flush, .jmpAddr, .idStall, .resolve, .irq,
                         .memReq, .memAddr, .memValid, .memData, .fetchPkt);

    fetchChecker i_fetchChecker (.Clk, .arstN, .flush, .jmpAddr, .idStall, .resolve, .irq,
                                 .memReq, .memAddr, .memValid, .fetchPkt,
                                 .pktCount, .checkCount, .errCount);

    always #4 Clk = ~Clk;

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // instruction image, address scrambled then rotated
    function automatic logic [`FETCH_XLEN-1:0] memWord(input logic [`FETCH_XLEN-1:0] addr);
        logic [`FETCH_XLEN-1:0] x;
        x = addr ^ 32'h5A3C_96E1;
        return {x[24:0], x[31:25]};
    endfunction

    // answers a request after 1 to 4 cycles with a one cycle strobe
    always @(posedge Clk)
    begin
        #1;
        if (memValid)
            memValid = 1'b0;
        else if (memReq)
        begin
            if (refillWait < 0)
            begin
                rngState = xorshift32(rngState);
                refillWait = 1 + int'(rngState % 32'd4);
            end
            refillWait = refillWait - 1;
            if (refillWait == 0)
            begin
                memValid = 1'b1;
                memData = memWord(memAddr);
                refillWait = -1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////////////////////////

    task automatic finishRun();
        $display("packets %0d, checks %0d, checker errors %0d, bench errors %0d",
                 pktCount, checkCount, errCount, benchErrors);
        if (errCount + benchErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            benchErrors = benchErrors + 1;
            finishRun();
        end
    end

    task automatic waitPackets(input int n);
        int target;
        target = pktCount + n;
        while (pktCount < target)
            @(posedge Clk);
    endtask

    task automatic pulseFlush(input logic [`FETCH_XLEN-1:0] addr);
        @(posedge Clk);
        #1;
        flush = 1'b1;
        jmpAddr = addr;
        @(posedge Clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic sendResolve(input logic [`FETCH_XLEN-1:0] pc,
                               input logic [`FETCH_XLEN-1:0] tgt, input logic taken);
        @(posedge Clk);
        #1;
        resolve = '{valid: 1'b1, pc: pc, target: tgt, taken: taken};
        @(posedge Clk);
        #1;
        resolve = '0;
    endtask

    task automatic pulseIrq(input logic [`IRQ_LINES-1:0] lines);
        @(posedge Clk);
        #1;
        irq = lines;
        @(posedge Clk);
        #1;
        irq = '0;
    endtask

    initial
    begin
        arstN = 1'b0;
        flush = 1'b0;
        jmpAddr = '0;
        idStall = 1'b0;
        resolve = '0;
        irq = '0;
        repeat (RESET_CYCLES) @(posedge Clk);
        #1;
        arstN = 1'b1;
        // cold sequential fetch from the reset vector
        waitPackets(P1_PKTS);
        // jump back into lines already filled
        pulseFlush(32'h20);
        waitPackets(P2_PKTS);
        // strong taken, then fetch across the branch
        sendResolve(BR_PC, BR_TGT, 1'b1);
        sendResolve(BR_PC, BR_TGT, 1'b1);
        pulseFlush(BR_PC - 32'd8);
        waitPackets(P3_PKTS);
        // weaken below threshold, fall through again
        sendResolve(BR_PC, BR_TGT, 1'b0);
        sendResolve(BR_PC, BR_TGT, 1'b0);
        pulseFlush(BR_PC - 32'd8);
        waitPackets(P3_PKTS);
        // single line, then lines 0 and 2 together
        pulseIrq(4'b0010);
        waitPackets(P4_PKTS);
        pulseIrq(4'b0101);
        waitPackets(P4_PKTS);
        // decode back-pressure
        @(posedge Clk);
        #1;
        idStall = 1'b1;
        repeat (STALL_CYCLES) @(posedge Clk);
        #1;
        idStall = 1'b0;
        waitPackets(P5_PKTS);
        finishRun();
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/fetchPkg.sv
rtl/pcUpdate.sv
rtl/branchPredictor.sv
rtl/instrCache.sv
rtl/vectorCtrl.sv
rtl/fetchTop.sv
bench/fetchChecker.sv
bench/fetchTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of the fetch testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module fetchTb \
    --Mdir obj_dir -o fetchSim \
    && ./obj_dir/fetchSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
